/* verilog.f */
+incdir+include
src/cmd_bus_pkg.sv
src/reg_map_pkg.sv
src/cmd_seq_mux.sv
src/cmd_decode.sv
src/reg_execute.sv
src/wr_result.sv
src/cmd_subsys_top.sv
test/tb_cmd_subsys.sv

/* Makefile */
TOP := tb_cmd_subsys
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f include/cmd_consts.svh src/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal -Iinclude -f verilog.f \
	    --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	    echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_cmd_subsys.sv */
`default_nettype none

`include "cmd_consts.svh"

module tb_cmd_subsys
    import cmd_bus_pkg::*, reg_map_pkg::*;
();

    localparam int NCH         = `CMD_NUM_CHN;
    localparam int RAND_PER_CH = 24;                         // random commands per channel
    localparam int HOLD_CYCLES = 40;                         // length of the hold window
    localparam int TOTAL_CMDS  = 16 + 16 + 4 * NCH + 8 + 2 * NCH + RAND_PER_CH * NCH;

    typedef struct packed {
        chn_cmd_t   cmd; // what the sequencer presents
        logic [3:0] gap; // idle cycles before raising wr_en
    } stim_t;

    logic           mclk = 1'b0;
    logic           rst  = 1'b1;
    chn_cmd_t       chn_cmd [NCH] = '{default: '0};
    logic [NCH-1:0] wr_en = '0;
    logic [NCH-1:0] ackn;
    logic           hold = 1'b0;
    reg_upd_t       upd;
    logic           upd_valid;
    logic [7:0]     bad_cnt;

    stim_t       stim_q [NCH][$];                 // commands not yet presented
    chn_cmd_t    exp_q  [NCH][$];                 // presented, report still due
    int          gap_cnt [NCH] = '{default: 0};   // idle cycles spent so far
    logic [31:0] model [`CMD_NUM_REGS];           // reference register bank
    logic [15:0] lfsr_state = 16'd25;
    int          exp_bad   = 0;                   // invalid commands presented
    int          errors    = 0;
    int          checks    = 0;
    int          ackn_seen = 0;                   // ackn pulses since reset
    int          upd_seen  = 0;                   // reports since reset
    int          solo_chn  = -1;                  // only channel allowed to report
    logic        rot_on    = 1'b0;                // check round-robin order
    int          rot_prev  = -1;                  // last reported channel

    cmd_subsys_top i_dut (
        .mclk      (mclk),
        .rst       (rst),
        .chn_cmd   (chn_cmd),
        .wr_en     (wr_en),
        .ackn      (ackn),
        .hold      (hold),
        .upd       (upd),
        .upd_valid (upd_valid),
        .bad_cnt   (bad_cnt)
    );

    always #4 mclk = ~mclk; // 8 unit period

    // galois lfsr, one step per random bit
    function automatic logic lfsr_step();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[15:1]};
        if (lsb) begin
            lfsr_state = lfsr_state ^ 16'hB400; // x^16+x^14+x^13+x^11+1
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // register index from the address map
    function automatic logic [3:0] exp_idx(input cmd_addr_t addr);
        cmd_addr_t off;
        off = addr;
        if (addr >= cmd_addr_t'(`CMD_MASK_BASE)) begin
            off = addr - cmd_addr_t'(`CMD_MASK_BASE); // masked window
        end
        return off[3:0];
    endfunction

    // value a register holds after one write
    function automatic logic [31:0] ref_write(input logic [31:0] old_val, input cmd_addr_t addr,
                                              input logic [31:0] data);
        logic [31:0] nv;
        if (addr < cmd_addr_t'(`CMD_MASK_BASE)) begin
            return data; // plain, whole word
        end
        nv = old_val; // upper half untouched
        for (int b = 0; b < 16; b++) begin
            if (data[16 + b]) begin
                nv[b] = data[b]; // mask bit set, new bit taken
            end
        end
        return nv;
    endfunction

    task automatic add_cmd(input int c, input int addr, input logic [31:0] data, input int gap);
        stim_t s;
        s.cmd.addr = cmd_addr_t'(addr);
        s.cmd.data = data;
        s.gap      = 4'(gap);
        stim_q[c].push_back(s);
    endtask

    // wait for every channel to be served and every report to arrive
    task automatic wait_drain();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge mclk);
            busy = (wr_en != '0);
            for (int c = 0; c < NCH; c++) begin
                if (stim_q[c].size() != 0 || exp_q[c].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        repeat (6) @(posedge mclk); // rejects reach bad_cnt 3 cycles after the take
    endtask

    task automatic check_bad();
        checks++;
        if (bad_cnt !== 8'(exp_bad)) begin
            $display("[ERROR] bad_cnt exp=%h got=%h", 8'(exp_bad), bad_cnt);
            errors++;
        end
    endtask

    task automatic finish_test(input int n, input string name, input int err0);
        $display("test %0d %s: %0d errors", n, name, errors - err0);
    endtask

    // sequencer models, hold wr_en until ackn then go to the next command
    always @(posedge mclk) begin
        stim_t cur;
        if (!rst) begin
            for (int c = 0; c < NCH; c++) begin
                if (!wr_en[c] || ackn[c]) begin             // idle or just served
                    if (stim_q[c].size() == 0) begin
                        wr_en[c] <= 1'b0;
                    end else if (gap_cnt[c] < int'(stim_q[c][0].gap)) begin
                        wr_en[c]   <= 1'b0;                 // request gap
                        gap_cnt[c] = gap_cnt[c] + 1;
                    end else begin
                        cur        = stim_q[c].pop_front();
                        chn_cmd[c] <= cur.cmd;
                        wr_en[c]   <= 1'b1;
                        gap_cnt[c] = 0;
                        if (cur.cmd.addr < cmd_addr_t'(`CMD_LIMIT)) begin
                            exp_q[c].push_back(cur.cmd);    // report expected
                        end else begin
                            exp_bad++;                      // counted only
                        end
                    end
                end
            end
        end
    end

    // compare each report against the model, in upd_valid order
    always @(posedge mclk) begin
        chn_cmd_t    e;
        int          ch;
        logic [3:0]  ix;
        logic [31:0] ev;
        if (!rst) begin
            ackn_seen = ackn_seen + $countones(ackn);
            if (upd_valid) begin
                upd_seen++;
                ch = int'(upd.chn);
                if (solo_chn >= 0 && ch != solo_chn) begin
                    $display("[ERROR] upd.chn exp=%h got=%h", 2'(solo_chn), upd.chn);
                    errors++;
                end
                if (rot_on) begin
                    if (rot_prev >= 0 && ch != (rot_prev + 1) % NCH) begin
                        $display("[ERROR] upd.chn exp=%h got=%h", 2'((rot_prev + 1) % NCH),
                                 upd.chn);
                        errors++;
                    end
                    rot_prev = ch;
                end
                if (exp_q[ch].size() == 0) begin
                    $display("report from channel %0d with no command outstanding", ch);
                    errors++;
                end else begin
                    e  = exp_q[ch].pop_front();   // order within a channel
                    ix = exp_idx(e.addr);
                    ev = ref_write(model[ix], e.addr, e.data);
                    checks++;
                    if (upd.idx !== ix) begin
                        $display("[ERROR] upd.idx exp=%h got=%h", ix, upd.idx);
                        errors++;
                    end
                    if (upd.value !== ev) begin
                        $display("[ERROR] upd.value exp=%h got=%h", ev, upd.value);
                        errors++;
                    end
                    model[ix] = ev;
                end
            end
        end
    end

    initial begin
        int err0;
        int ack0;
        int upd0;
        for (int r = 0; r < `CMD_NUM_REGS; r++) begin
            model[r] = '0; // bank is cleared by reset
        end
        repeat (3) @(posedge mclk);
        rst <= 1'b0;

        err0     = errors;      // plain writes, every register
        solo_chn = 0;
        for (int r = 0; r < 16; r++) begin
            add_cmd(0, r, rand_bits(32), 0);
        end
        wait_drain();
        check_bad();
        finish_test(1, "plain writes from channel 0", err0);

        err0     = errors;      // masked writes on top of test 1 values
        solo_chn = 2;
        for (int r = 0; r < 16; r++) begin
            add_cmd(2, `CMD_MASK_BASE + r, rand_bits(32), 0);
        end
        wait_drain();
        check_bad();
        finish_test(2, "masked writes", err0);

        err0     = errors;      // all channels back to back
        solo_chn = -1;
        rot_on   = 1'b1;
        rot_prev = -1;
        for (int c = 0; c < NCH; c++) begin
            for (int k = 0; k < 4; k++) begin
                add_cmd(c, c * 4 + k, rand_bits(32), 0);
            end
        end
        wait_drain();
        rot_on = 1'b0;
        check_bad();
        finish_test(3, "round robin on four channels", err0);

        err0 = errors;          // out of map
        upd0 = upd_seen;
        add_cmd(0, `CMD_LIMIT, rand_bits(32), 0);
        for (int i = 1; i < 8; i++) begin
            add_cmd(i % NCH, `CMD_LIMIT + int'(rand_bits(12)), rand_bits(32), 0);
        end
        wait_drain();
        checks++;
        if (upd_seen != upd0) begin
            $display("register update reported for an invalid address");
            errors++;
        end
        check_bad();
        finish_test(4, "invalid addresses", err0);

        err0 = errors;          // hold with requests pending
        ack0 = ackn_seen;
        upd0 = upd_seen;
        @(posedge mclk);
        hold <= 1'b1;
        for (int c = 0; c < NCH; c++) begin
            add_cmd(c, int'(rand_bits(5)), rand_bits(32), 0);
            add_cmd(c, int'(rand_bits(5)), rand_bits(32), 0);
        end
        repeat (HOLD_CYCLES) @(posedge mclk);
        checks++;
        if (ackn_seen - ack0 != 1) begin // only the empty mux output may fill
            $display("%0d channel acknowledges during hold, one expected", ackn_seen - ack0);
            errors++;
        end
        if (upd_seen != upd0) begin
            $display("register update reported while hold was high");
            errors++;
        end
        hold <= 1'b0;
        wait_drain();
        check_bad();
        finish_test(5, "hold and release", err0);

        err0 = errors;          // random mix with gaps
        for (int c = 0; c < NCH; c++) begin
            for (int i = 0; i < RAND_PER_CH; i++) begin
                add_cmd(c, int'(rand_bits(6)), rand_bits(32), int'(rand_bits(2)));
            end
        end
        wait_drain();
        check_bad();
        finish_test(6, "random mixed traffic", err0);

        $display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // about 20 cycles per command is far beyond the worst arbitration wait
    initial begin
        repeat (TOTAL_CMDS * 20) @(posedge mclk);
        $display("timeout: commands still outstanding after %0d cycles", TOTAL_CMDS * 20);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src/cmd_subsys_top.sv */
`default_nettype none

`include "cmd_consts.svh"

module cmd_subsys_top
    import cmd_bus_pkg::*, reg_map_pkg::*;
(
    input  wire                     mclk,                   // system clock
    input  wire                     rst,                    // async reset, active high
    input  chn_cmd_t                chn_cmd [`CMD_NUM_CHN], // sequencer commands
    input  wire [`CMD_NUM_CHN-1:0]  wr_en,                  // sequencer request levels
    output logic [`CMD_NUM_CHN-1:0] ackn,                   // accept pulses back
    input  wire                     hold,                   // pause acceptance
    output reg_upd_t                upd,                    // register update report
    output logic                    upd_valid,              // report strobe
    output logic [7:0]              bad_cnt                 // rejected commands
);

    mux_cmd_t cmd;        // mux output word
    logic     cmd_valid;  // mux full
    logic     cmd_ackn;   // decoder took the word
    reg_op_t  op;         // decoded op
    logic     op_valid;   // op strobe
    reg_upd_t exe_upd;    // report out of execute
    logic     upd_strobe; // exe_upd strobe
    logic     reject;     // invalid op seen

    cmd_seq_mux i_mux (
        .mclk      (mclk),
        .rst       (rst),
        .chn_cmd   (chn_cmd),
        .wr_en     (wr_en),
        .ackn      (ackn),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ackn  (cmd_ackn)
    );

    cmd_decode i_decode (
        .mclk      (mclk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .hold      (hold),
        .cmd_ackn  (cmd_ackn),
        .op        (op),
        .op_valid  (op_valid)
    );

    reg_execute i_execute (
        .mclk       (mclk),
        .rst        (rst),
        .op         (op),
        .op_valid   (op_valid),
        .upd        (exe_upd),
        .upd_strobe (upd_strobe),
        .reject     (reject)
    );

    wr_result i_result (
        .mclk       (mclk),
        .rst        (rst),
        .upd_in     (exe_upd),
        .upd_strobe (upd_strobe),
        .reject     (reject),
        .upd        (upd),
        .upd_valid  (upd_valid),
        .bad_cnt    (bad_cnt)
    );

endmodule

`default_nettype wire

/* src/wr_result.sv */
`default_nettype none

module wr_result
    import reg_map_pkg::*;
(
    input  wire        mclk,       // system clock
    input  wire        rst,        // async reset, active high
    input  reg_upd_t   upd_in,     // report from execute
    input  wire        upd_strobe, // upd_in is valid
    input  wire        reject,     // execute dropped an op
    output reg_upd_t   upd,        // registered report
    output logic       upd_valid,  // upd strobe
    output logic [7:0] bad_cnt     // rejected ops, saturating
);

    logic cnt_full; // counter at its top value

    assign cnt_full = &bad_cnt;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            upd_valid <= 1'b0;
            bad_cnt   <= '0;
        end else begin
            upd_valid <= upd_strobe; // one stage behind execute
            if (reject && !cnt_full) begin
                bad_cnt <= bad_cnt + 8'd1; // stick at 255
            end
        end
    end

    // report payload, qualified by upd_valid
    always_ff @(posedge mclk) begin
        if (upd_strobe) begin
            upd <= upd_in;
        end
    end

endmodule

`default_nettype wire

/* src/reg_execute.sv */
`default_nettype none

`include "cmd_consts.svh"

module reg_execute
    import reg_map_pkg::*;
(
    input  wire      mclk,       // system clock
    input  wire      rst,        // async reset, active high
    input  reg_op_t  op,         // decoded operation
    input  wire      op_valid,   // op strobe
    output reg_upd_t upd,        // update report
    output logic     upd_strobe, // a register was written
    output logic     reject      // op was out of map
);

    logic [31:0] regs [`CMD_NUM_REGS]; // sensor control bank
    cmd_data_u   d;                    // op payload, two views
    logic [31:0] old_val;              // current register content
    logic [31:0] new_val;              // content after this op
    logic        wr_ok;                // valid op that writes

    assign d       = op.data;
    assign old_val = regs[op.idx];
    assign wr_ok   = op_valid && (op.kind != OP_INVALID);

    always_comb begin
        case (op.kind)
            OP_PLAIN:  new_val = d.word; // full replace
            OP_MASKED: begin
                // upper half kept, selected low bits swapped in
                new_val = {old_val[31:16],
                           (old_val[15:0] & ~d.msk.mask) | (d.msk.bits & d.msk.mask)};
            end
            default:   new_val = old_val; // no change
        endcase
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CMD_NUM_REGS; i++) begin
                regs[i] <= '0; // registers start cleared
            end
            upd_strobe <= 1'b0;
            reject     <= 1'b0;
        end else begin
            upd_strobe <= wr_ok;
            reject     <= op_valid && (op.kind == OP_INVALID); // for bad_cnt
            if (wr_ok) begin
                regs[op.idx] <= new_val;
            end
        end
    end

    // report carries the value as written
    always_ff @(posedge mclk) begin
        if (wr_ok) begin
            upd.idx   <= op.idx;
            upd.value <= new_val;
            upd.chn   <= op.chn;
        end
    end

    // decoder never sends the unused kind encoding
    a_kind_known: assert property (@(posedge mclk) disable iff (rst)
        op_valid |-> op.kind inside {OP_PLAIN, OP_MASKED, OP_INVALID});

endmodule

`default_nettype wire

/* src/cmd_decode.sv */
`default_nettype none

`include "cmd_consts.svh"

module cmd_decode
    import cmd_bus_pkg::*, reg_map_pkg::*;
(
    input  wire      mclk,      // system clock
    input  wire      rst,       // async reset, active high
    input  mux_cmd_t cmd,       // word from the mux
    input  wire      cmd_valid, // mux output is full
    input  wire      hold,      // frame logic pauses acceptance
    output logic     cmd_ackn,  // word taken this cycle
    output reg_op_t  op,        // decoded operation
    output logic     op_valid   // op strobe
);

    reg_op_e   kind_w;   // classification of cmd.addr
    reg_idx_t  idx_w;    // bank index for kind_w

    assign cmd_ackn = cmd_valid && !hold; // take whenever not paused
    assign idx_w    = cmd.addr[$bits(reg_idx_t)-1:0]; // both windows start on a bank boundary

    // address map split, invalid ops still travel down to be counted
    always_comb begin
        if (cmd.addr < cmd_addr_t'(`CMD_MASK_BASE)) begin
            kind_w = OP_PLAIN;
        end else if (cmd.addr < cmd_addr_t'(`CMD_LIMIT)) begin
            kind_w = OP_MASKED;
        end else begin
            kind_w = OP_INVALID;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= cmd_ackn; // one cycle after the take
        end
    end

    // pipeline payload, qualified by op_valid
    always_ff @(posedge mclk) begin
        if (cmd_ackn) begin
            op.kind      <= kind_w;
            op.idx       <= idx_w;
            op.data.word <= cmd.data; // view picked later by kind
            op.chn       <= cmd.chn;
        end
    end

    // a word left waiting under hold must not change in the mux
    a_cmd_stable: assert property (@(posedge mclk) disable iff (rst)
        cmd_valid && !cmd_ackn |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

/* src/cmd_seq_mux.sv */
`default_nettype none

`include "cmd_consts.svh"

module cmd_seq_mux
    import cmd_bus_pkg::*;
(
    input  wire                     mclk,                   // system clock
    input  wire                     rst,                    // async reset, active high
    input  chn_cmd_t                chn_cmd [`CMD_NUM_CHN], // per-channel address/data
    input  wire [`CMD_NUM_CHN-1:0]  wr_en,                  // per-channel request levels
    output logic [`CMD_NUM_CHN-1:0] ackn,                   // one-cycle accept pulses
    output mux_cmd_t                cmd,                    // forwarded command
    output logic                    cmd_valid,              // cmd holds an unaccepted word
    input  wire                     cmd_ackn                // downstream took cmd
);

    logic [`CMD_NUM_CHN-1:0] req;                   // requests minus the ones just acked
    logic [`CMD_NUM_CHN-1:0] pri_tbl [`CMD_NUM_CHN]; // one-hot winner per last served
    logic [`CMD_NUM_CHN-1:0] pri_one;               // row for current last_chn
    chn_id_t                 win;                   // encoded winner
    chn_id_t                 last_chn;              // last served channel
    logic                    rq_any;                // someone is asking
    logic                    take;                  // accept a new word this cycle
    logic                    full_r;                // output register occupied

    // a channel sees its ackn one cycle late, so its level is stale then
    assign req = wr_en & ~ackn;

    // for every possible last channel scan from the far end back towards
    // last+1 so the nearest higher requester (with wrap) is kept
    always_comb begin
        for (int l = 0; l < `CMD_NUM_CHN; l++) begin
            pri_tbl[l] = '0;
            for (int k = `CMD_NUM_CHN; k >= 1; k--) begin
                if (req[(l + k) % `CMD_NUM_CHN]) begin
                    pri_tbl[l] = '0;                          // drop the farther one
                    pri_tbl[l][(l + k) % `CMD_NUM_CHN] = 1'b1; // nearer requester wins
                end
            end
        end
    end

    assign pri_one = pri_tbl[last_chn]; // round-robin pick

    always_comb begin
        win = '0;
        for (int i = 0; i < `CMD_NUM_CHN; i++) begin
            if (pri_one[i]) begin
                win = chn_id_t'(i); // pri_one is one-hot or zero
            end
        end
    end

    assign rq_any    = |req;
    assign take      = rq_any && (!full_r || cmd_ackn); // free or being emptied
    assign cmd_valid = full_r;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            full_r   <= 1'b0;
            ackn     <= '0;
            last_chn <= '0; // so channel 1 is first in line after reset
        end else begin
            ackn <= take ? pri_one : '0; // pulse to the winner only
            if (take) begin
                full_r   <= 1'b1;
                last_chn <= win;
            end else if (cmd_ackn) begin
                full_r   <= 1'b0; // drained, nothing new
            end
        end
    end

    // payload register, only meaningful while full_r
    always_ff @(posedge mclk) begin
        if (take) begin
            cmd.addr <= chn_cmd[win].addr;
            cmd.data <= chn_cmd[win].data;
            cmd.chn  <= win;
        end
    end

    // a single channel is served per accepted word
    a_ackn_onehot: assert property (@(posedge mclk) disable iff (rst)
        $onehot0(ackn));

endmodule

`default_nettype wire

/* src/reg_map_pkg.sv */
`default_nettype none

`include "cmd_consts.svh"

package reg_map_pkg;

    import cmd_bus_pkg::chn_id_t;

    typedef logic [$clog2(`CMD_NUM_REGS)-1:0] reg_idx_t; // bank index

    // the same data word read two ways
    typedef union packed {
        logic [31:0] word;     // plain write value
        struct packed {
            logic [15:0] mask; // 1 = take bit from bits
            logic [15:0] bits; // new low-half values
        } msk;
    } cmd_data_u;

    typedef enum logic [1:0] {
        OP_PLAIN   = 2'd0, // replace register
        OP_MASKED  = 2'd1, // masked low half update
        OP_INVALID = 2'd2  // out of map, counted only
    } reg_op_e;

    typedef struct packed {
        reg_op_e   kind; // decoded class
        reg_idx_t  idx;  // register index within bank
        cmd_data_u data; // payload, view chosen by kind
        chn_id_t   chn;  // source channel
    } reg_op_t;

    typedef struct packed {
        reg_idx_t    idx;   // register written
        logic [31:0] value; // value after the write
        chn_id_t     chn;   // source channel
    } reg_upd_t;

endpackage

`default_nettype wire

/* src/cmd_bus_pkg.sv */
`default_nettype none

`include "cmd_consts.svh"

package cmd_bus_pkg;

    // source channel number, 2 bits for 4 channels
    typedef logic [$clog2(`CMD_NUM_CHN)-1:0] chn_id_t;

    // register address as sent by a sequencer
    typedef logic [`CMD_ADDR_BITS-1:0] cmd_addr_t;

    // what one sequencer presents together with its wr_en level
    typedef struct packed {
        cmd_addr_t   addr; // target register address
        logic [31:0] data; // write data, plain or mask+bits
    } chn_cmd_t;

    // word forwarded by the mux, tagged with the winner
    typedef struct packed {
        cmd_addr_t   addr; // copied from winning channel
        logic [31:0] data; // copied from winning channel
        chn_id_t     chn;  // which sequencer it came from
    } mux_cmd_t;

endpackage

`default_nettype wire

/* include/cmd_consts.svh */
`ifndef CMD_CONSTS_SVH
`define CMD_CONSTS_SVH

// register address width, one word per address
`define CMD_ADDR_BITS 14

// sequencer channels feeding the mux
`define CMD_NUM_CHN 4

// sensor control registers in the bank
`define CMD_NUM_REGS 16

// address map
//   0 .. MASK_BASE-1      plain write, whole register
//   MASK_BASE .. LIMIT-1  masked write, low half only
//   LIMIT and above       rejected
`define CMD_MASK_BASE 16
`define CMD_LIMIT 32

`endif
